//--- verilog.f
hdl/rom_map_pkg.sv
hdl/bus_pkg.sv
hdl/download_decoder.sv
hdl/rom_request_port.sv
hdl/sdram_arbiter.sv
hdl/game_top.sv
verification/tb_sdram_model.sv
verification/tb_game_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_game_top -f verilog.f --Mdir obj_dir
./obj_dir/Vtb_game_top > sim.log 2>&1
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

//--- verification/tb_game_top.sv
`timescale 1ns/1ps
// Testbench for game_top: stimulus, ROM reference model, checks, handshake monitor, watchdog
module tb_game_top;
	import rom_map_pkg::*;
	import bus_pkg::*;

	// Small regions keep the download short, 32 words per region
	localparam int unsigned REGION_BYTES = 64;
	localparam int WORDS_PER_REGION = 32;
	localparam int ROM_WORDS = 4 * WORDS_PER_REGION;
	// Words sent past the sprite region, which the decoder must drop
	localparam int EXTRA_WORDS = 16;
	localparam int SINGLE_READS = 4;
	localparam int CONC_READS = 8;

	// Every download word, read-back and client read gets a worst-case slot
	localparam int CYCLES_PER_WORD = 64;
	localparam int TOTAL_WORDS = 5 + 2 * (ROM_WORDS + EXTRA_WORDS)
		+ 4 * (SINGLE_READS + CONC_READS);
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * CYCLES_PER_WORD;

	logic        clk_sys;
	logic        rst;
	dl_word_t    dl_word;
	logic        dl_wr;
	logic        dl_wait;
	logic [23:0] dip_sw;
	logic [3:0]  title_no;
	logic        cl_req [4];
	logic [18:0] cl_addr [4];
	logic [31:0] cl_data [4];
	logic [3:0]  req_vec;
	logic [3:0]  ack_vec;
	logic [15:0] m68k_data;
	logic [31:0] spr_data;
	logic [31:0] tile_data;
	logic [31:0] theme_data;
	mem_req_t    mem_req;
	logic        mem_ready;
	rd_data_t    mem_rdata;
	sdram_addr_t peek_addr;
	logic [15:0] peek_data;
	logic        peek_hit;
	logic [31:0] wr_count;

	// Reference ROM contents in stream word order: 68k, theme, tiles, sprites
	logic [15:0] ref_rom [ROM_WORDS];
	integer      seed;
	string       test_name;
	string       client_name [4] = '{"m68k", "spr", "tile", "theme"};
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	int          hs_errors;
	int          hs_start;
	logic [3:0]  ack_prev;
	logic [3:0]  req_prev;

	game_top #(
		.M68K_BYTES    (REGION_BYTES),
		.THEME_BYTES   (REGION_BYTES),
		.TILES_BYTES   (REGION_BYTES),
		.SPRITES_BYTES (REGION_BYTES)
	) dut0 (
		.clk_sys, .rst, .dl_word, .dl_wr, .dl_wait, .dip_sw, .title_no,
		.m68k_req(cl_req[0]), .m68k_addr(cl_addr[0][17:0]), .m68k_ack(ack_vec[0]), .m68k_data,
		.spr_req(cl_req[1]), .spr_addr(cl_addr[1]), .spr_ack(ack_vec[1]), .spr_data,
		.tile_req(cl_req[2]), .tile_addr(cl_addr[2][17:0]), .tile_ack(ack_vec[2]), .tile_data,
		.theme_req(cl_req[3]), .theme_addr(cl_addr[3][17:0]), .theme_ack(ack_vec[3]), .theme_data,
		.mem_req, .mem_ready, .mem_rdata
	);

	tb_sdram_model #(.SEED(71)) mem0 (
		.clk_sys, .rst, .mem_req, .mem_ready, .mem_rdata,
		.peek_addr, .peek_data, .peek_hit, .wr_count
	);

	// Client index order follows arbiter priority
	assign req_vec = {cl_req[3], cl_req[2], cl_req[1], cl_req[0]};
	assign cl_data[0] = {16'h0000, m68k_data};
	assign cl_data[1] = spr_data;
	assign cl_data[2] = tile_data;
	assign cl_data[3] = theme_data;

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic sdram_addr_t region_base(input int r);
		case (r)
			0: return M68K_BASE;
			1: return THEME_BASE;
			2: return TILES_BASE;
			default: return SPRITES_BASE;
		endcase
	endfunction

	// Stream region that each client reads from
	function automatic int client_region(input int c);
		case (c)
			0: return 0;
			1: return 3;
			2: return 2;
			default: return 1;
		endcase
	endfunction

	// 68k reads one word, the others the addressed word pair with the first in the low half
	function automatic logic [31:0] expected_read(input int c, input int a);
		int base_w;
		base_w = client_region(c) * WORDS_PER_REGION;
		if (c == 0)
			return {16'h0000, ref_rom[base_w + a]};
		return {ref_rom[base_w + 2 * a + 1], ref_rom[base_w + 2 * a]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bookkeeping and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
		hs_start = hs_errors;
	endtask

	task automatic end_test();
		test_errors = test_errors + (hs_errors - hs_start);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %s: %s, %0d checks, %0d errors", test_name,
			(test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
	endtask

	task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		checks++;
		test_checks++;
		if (exp_v !== act_v) begin
			$display("** Error: %s %s expected %h actual %h", test_name, what, exp_v, act_v);
			errors++;
			test_errors++;
		end
	endtask

	// An ack that rises while its req was low at the same edge breaks the handshake
	always @(posedge clk_sys) begin
		if (rst) begin
			ack_prev <= '0;
			req_prev <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (ack_vec[i] && !ack_prev[i] && !req_prev[i]) begin
					$display("Handshake error in %s: ack of %s rose without its req",
						test_name, client_name[i]);
					hs_errors++;
				end
			end
			ack_prev <= ack_vec;
			req_prev <= req_vec;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// The word is taken at the rising edge after dl_wr is set with dl_wait low
	task automatic send_word(input logic [15:0] idx, input sdram_addr_t a, input logic [15:0] d);
		@(negedge clk_sys);
		while (dl_wait)
			@(negedge clk_sys);
		dl_word = '{index: idx, addr: a, data: d};
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic peek_word(input sdram_addr_t a, output logic [15:0] d, output logic hit);
		@(negedge clk_sys);
		peek_addr = a;
		@(negedge clk_sys);
		d = peek_data;
		hit = peek_hit;
	endtask

	// One full four-phase transfer for client c
	task automatic client_read(input int c, input int a);
		logic [31:0] exp_val;
		exp_val = expected_read(c, a);
		@(negedge clk_sys);
		check({client_name[c], " ack before req"}, 32'd0, 32'(ack_vec[c]));
		cl_addr[c] = 19'(a);
		cl_req[c] = 1'b1;
		@(negedge clk_sys);
		while (!ack_vec[c])
			@(negedge clk_sys);
		check($sformatf("%s data at %0d", client_name[c], a), exp_val, cl_data[c]);
		cl_req[c] = 1'b0;
		@(negedge clk_sys);
		check({client_name[c], " ack release"}, 32'd0, 32'(ack_vec[c]));
	endtask

	task automatic run_client(input int c);
		int gap;
		int a;
		for (int k = 0; k < CONC_READS; k++) begin
			gap = int'($unsigned($random(seed)) % 4);
			a = int'($unsigned($random(seed)) % ((c == 0) ? 32 : 16));
			repeat (gap) @(negedge clk_sys);
			client_read(c, a);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] d0;
		logic [15:0] d1;
		logic [15:0] d2;
		logic        hit;
		int          a;
		seed = 71;
		rst = 1'b1;
		dl_word = '0;
		dl_wr = 1'b0;
		peek_addr = '0;
		for (int i = 0; i < 4; i++) begin
			cl_req[i] = 1'b0;
			cl_addr[i] = '0;
		end
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;

		start_test("reset_state");
		check("dip_sw", 32'h00ff_ffff, 32'(dip_sw));
		check("title_no", 32'd1, 32'(title_no));
		check("dl_wait", 32'd0, 32'(dl_wait));
		check("ack", 32'd0, 32'(ack_vec));
		check("mem_req flags", 32'd0, 32'({mem_req.rd, mem_req.wr}));
		end_test();

		start_test("dip_and_title");
		d0 = 16'($random(seed));
		d1 = 16'($random(seed));
		d2 = 16'($random(seed));
		// The title must differ from its reset value to show the capture
		if (d2[3:0] == 4'd1)
			d2[3:0] = 4'd2;
		send_word(IDX_DIPS, 27'd0, d0);
		send_word(IDX_DIPS, 27'd2, d1);
		// Byte address 4 lies past the DIP bytes and leaves them alone
		send_word(IDX_DIPS, 27'd4, ~d0);
		send_word(IDX_TITLE, 27'd0, d2);
		check("dip_sw", 32'({d1[7:0], d0}), 32'(dip_sw));
		check("title_no", 32'(d2[3:0]), 32'(title_no));
		end_test();

		start_test("rom_download");
		for (int w = 0; w < ROM_WORDS + EXTRA_WORDS; w++) begin
			d0 = 16'($random(seed));
			if (w < ROM_WORDS)
				ref_rom[w] = d0;
			send_word(IDX_ROM, sdram_addr_t'(2 * w), d0);
			// A ROM word holds off the host, a dropped word does not
			check($sformatf("dl_wait after word %0d", w), 32'(w < ROM_WORDS), 32'(dl_wait));
		end
		@(negedge clk_sys);
		while (dl_wait)
			@(negedge clk_sys);
		check("write count", 32'(ROM_WORDS), wr_count);
		for (int w = 0; w < ROM_WORDS; w++) begin
			peek_word(region_base(w / WORDS_PER_REGION)
				+ sdram_addr_t'(2 * (w % WORDS_PER_REGION)), d0, hit);
			check($sformatf("word %0d", w), {15'd0, 1'b1, ref_rom[w]}, {15'd0, hit, d0});
		end
		// The extra words would land right after the sprite region if kept
		for (int k = 0; k < EXTRA_WORDS; k++) begin
			peek_word(SPRITES_BASE + sdram_addr_t'(REGION_BYTES + 2 * k), d0, hit);
			check($sformatf("extra word %0d present", k), 32'd0, 32'(hit));
		end
		end_test();

		start_test("single_reads");
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < SINGLE_READS; k++) begin
				a = int'($unsigned($random(seed)) % ((c == 0) ? 32 : 16));
				client_read(c, a);
			end
		end
		end_test();

		start_test("concurrent_reads");
		fork
			run_client(0);
			run_client(1);
			run_client(2);
			run_client(3);
		join
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
			tests_failed, checks, errors + hs_errors);
		if (errors + hs_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog for a stalled download or handshake
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles, a transfer stalled",
			WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verification/tb_sdram_model.sv
`timescale 1ns/1ps
// SDRAM model: byte memory with random ready latency, write counter and read-back port
module tb_sdram_model #(
	parameter int SEED = 71
) (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  bus_pkg::mem_req_t        mem_req,
	output logic                     mem_ready,
	output bus_pkg::rd_data_t        mem_rdata,
	input  rom_map_pkg::sdram_addr_t peek_addr,
	output logic [15:0]              peek_data,
	output logic                     peek_hit,
	output logic [31:0]              wr_count
);
	import rom_map_pkg::*;
	import bus_pkg::*;

	// Sparse byte storage, only written bytes exist
	logic [7:0] mem [sdram_addr_t];
	integer     seed;
	logic       active;
	logic [2:0] wait_cnt;

	// Bytes never written read back as zero
	function automatic logic [7:0] read_byte(input sdram_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return 8'h00;
	endfunction

	initial seed = SEED;

	always @(posedge clk_sys) begin
		if (rst) begin
			mem_ready <= 1'b0;
			active    <= 1'b0;
			wait_cnt  <= '0;
			wr_count  <= '0;
		end else begin
			mem_ready <= 1'b0;
			if (mem_ready) begin
				// The arbiter retires its request on this edge
				active <= 1'b0;
			end else if (!active && (mem_req.rd || mem_req.wr)) begin
				active   <= 1'b1;
				wait_cnt <= 3'(1 + $unsigned($random(seed)) % 5);
			end else if (active) begin
				if (wait_cnt == 3'd1) begin
					mem_ready <= 1'b1;
					// Little endian, the low data byte sits at the even address
					if (mem_req.wr) begin
						mem[mem_req.addr]         = mem_req.wdata[7:0];
						mem[mem_req.addr + 27'd1] = mem_req.wdata[15:8];
						wr_count <= wr_count + 32'd1;
					end
					mem_rdata <= {read_byte(mem_req.addr + 27'd3), read_byte(mem_req.addr + 27'd2),
						read_byte(mem_req.addr + 27'd1), read_byte(mem_req.addr)};
				end else begin
					wait_cnt <= wait_cnt - 3'd1;
				end
			end
		end
		// Read-back for the testbench, one cycle behind peek_addr
		peek_data <= {read_byte(peek_addr + 27'd1), read_byte(peek_addr)};
		peek_hit  <= mem.exists(peek_addr) && mem.exists(peek_addr + 27'd1);
	end

endmodule

//--- hdl/game_top.sv
`timescale 1ns/1ps
// Game top level: download decoder, four ROM read ports and the SDRAM arbiter
module game_top #(
	parameter int unsigned M68K_BYTES    = rom_map_pkg::M68K_BYTES,
	parameter int unsigned THEME_BYTES   = rom_map_pkg::THEME_BYTES,
	parameter int unsigned TILES_BYTES   = rom_map_pkg::TILES_BYTES,
	parameter int unsigned SPRITES_BYTES = rom_map_pkg::SPRITES_BYTES
) (
	input  logic              clk_sys,
	input  logic              rst,

	// Host download stream
	input  bus_pkg::dl_word_t dl_word,
	input  logic              dl_wr,
	output logic              dl_wait,
	output logic [23:0]       dip_sw,
	output logic [3:0]        title_no,

	// 68k program words
	input  logic              m68k_req,
	input  logic [17:0]       m68k_addr,
	output logic              m68k_ack,
	output logic [15:0]       m68k_data,

	// Sprite data
	input  logic              spr_req,
	input  logic [18:0]       spr_addr,
	output logic              spr_ack,
	output logic [31:0]       spr_data,

	// Tile data
	input  logic              tile_req,
	input  logic [17:0]       tile_addr,
	output logic              tile_ack,
	output logic [31:0]       tile_data,

	// Theme data
	input  logic              theme_req,
	input  logic [17:0]       theme_addr,
	output logic              theme_ack,
	output logic [31:0]       theme_data,

	// Memory port
	output bus_pkg::mem_req_t mem_req,
	input  logic              mem_ready,
	input  bus_pkg::rd_data_t mem_rdata
);
	import rom_map_pkg::*;
	import bus_pkg::*;

	// Arbiter slots, in priority order
	localparam int RD_M68K  = 0;
	localparam int RD_SPR   = 1;
	localparam int RD_TILE  = 2;
	localparam int RD_THEME = 3;

	logic              wr_valid;
	mem_req_t          wr_req;
	logic              wr_done;
	logic [3:0]        rd_valid;
	rd_req_t [3:0]     rd_req;
	logic [3:0]        grant_done;
	rd_data_t          rd_data;

	download_decoder #(
		.M68K_BYTES    (M68K_BYTES),
		.THEME_BYTES   (THEME_BYTES),
		.TILES_BYTES   (TILES_BYTES),
		.SPRITES_BYTES (SPRITES_BYTES)
	) u_decoder (
		.clk_sys, .rst, .dl_word, .dl_wr, .dl_wait, .dip_sw, .title_no,
		.wr_valid, .wr_req, .wr_done
	);

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// The 68k fetches single 16-bit words, the others fetch 32 bits at a time
	rom_request_port #(.data_t(logic [15:0]), .REGION_BASE(M68K_BASE)) u_m68k_port (
		.clk_sys, .rst, .req(m68k_req), .addr(sdram_addr_t'(m68k_addr)),
		.ack(m68k_ack), .data(m68k_data),
		.rd_valid(rd_valid[RD_M68K]), .rd_req(rd_req[RD_M68K]),
		.grant_done(grant_done[RD_M68K]), .rd_data
	);

	rom_request_port #(.data_t(logic [31:0]), .REGION_BASE(SPRITES_BASE)) u_spr_port (
		.clk_sys, .rst, .req(spr_req), .addr(sdram_addr_t'(spr_addr)),
		.ack(spr_ack), .data(spr_data),
		.rd_valid(rd_valid[RD_SPR]), .rd_req(rd_req[RD_SPR]),
		.grant_done(grant_done[RD_SPR]), .rd_data
	);

	rom_request_port #(.data_t(logic [31:0]), .REGION_BASE(TILES_BASE)) u_tile_port (
		.clk_sys, .rst, .req(tile_req), .addr(sdram_addr_t'(tile_addr)),
		.ack(tile_ack), .data(tile_data),
		.rd_valid(rd_valid[RD_TILE]), .rd_req(rd_req[RD_TILE]),
		.grant_done(grant_done[RD_TILE]), .rd_data
	);

	rom_request_port #(.data_t(logic [31:0]), .REGION_BASE(THEME_BASE)) u_theme_port (
		.clk_sys, .rst, .req(theme_req), .addr(sdram_addr_t'(theme_addr)),
		.ack(theme_ack), .data(theme_data),
		.rd_valid(rd_valid[RD_THEME]), .rd_req(rd_req[RD_THEME]),
		.grant_done(grant_done[RD_THEME]), .rd_data
	);

	sdram_arbiter u_arbiter (
		.clk_sys, .rst, .wr_valid, .wr_req, .wr_done,
		.rd_valid, .rd_req, .grant_done, .rd_data,
		.mem_req, .mem_ready, .mem_rdata
	);

endmodule

//--- hdl/sdram_arbiter.sv
`timescale 1ns/1ps
// SDRAM arbiter: fixed-priority selection of the download write and four read ports
module sdram_arbiter (
	input  logic                   clk_sys,
	input  logic                   rst,

	// Download writer
	input  logic                   wr_valid,
	input  bus_pkg::mem_req_t      wr_req,
	output logic                   wr_done,

	// Read ports, index 0 has the highest priority
	input  logic [3:0]             rd_valid,
	input  bus_pkg::rd_req_t [3:0] rd_req,
	output logic [3:0]             grant_done,
	output bus_pkg::rd_data_t      rd_data,

	// Memory port
	output bus_pkg::mem_req_t      mem_req,
	input  logic                   mem_ready,
	input  bus_pkg::rd_data_t      mem_rdata
);

	localparam int NUM_RD = 4;

	logic       busy;
	logic       gnt_wr;
	logic [1:0] gnt_idx;
	logic       wr_pend;
	logic [3:0] rd_pend;
	logic [1:0] rd_sel;

	////////////////////////////////////////////////////////////////////////////
	// Selection
	////////////////////////////////////////////////////////////////////////////

	// A requester that was just served still shows valid for one more cycle
	// Its done pulse masks it so the same request is not granted twice
	assign wr_pend = wr_valid & ~wr_done;
	assign rd_pend = rd_valid & ~grant_done;

	// Lowest pending index wins among the reads
	always_comb begin
		rd_sel = '0;
		for (int i = NUM_RD - 1; i >= 0; i--) begin
			if (rd_pend[i])
				rd_sel = 2'(i);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Grant and memory request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			busy       <= 1'b0;
			mem_req.rd <= 1'b0;
			mem_req.wr <= 1'b0;
			wr_done    <= 1'b0;
			grant_done <= '0;
		end else begin
			// Done strobes last one cycle
			wr_done    <= 1'b0;
			grant_done <= '0;

			if (busy) begin
				// The request stays on the port until the memory answers
				if (mem_ready) begin
					busy       <= 1'b0;
					mem_req.rd <= 1'b0;
					mem_req.wr <= 1'b0;
					if (gnt_wr) begin
						wr_done <= 1'b1;
					end else begin
						grant_done[gnt_idx] <= 1'b1;
						rd_data             <= mem_rdata;
					end
				end
			end else if (wr_pend) begin
				// Download writes go ahead of every reader
				busy          <= 1'b1;
				gnt_wr        <= 1'b1;
				mem_req.rd    <= 1'b0;
				mem_req.wr    <= 1'b1;
				mem_req.addr  <= wr_req.addr;
				mem_req.wdata <= wr_req.wdata;
			end else if (|rd_pend) begin
				busy          <= 1'b1;
				gnt_wr        <= 1'b0;
				gnt_idx       <= rd_sel;
				mem_req.rd    <= 1'b1;
				mem_req.wr    <= 1'b0;
				mem_req.addr  <= rd_req[rd_sel].addr;
				mem_req.wdata <= '0;
			end
		end
	end

endmodule

//--- hdl/rom_request_port.sv
`timescale 1ns/1ps
// ROM request port: four-phase client handshake to arbiter read request adapter
module rom_request_port #(
	parameter type                      data_t      = logic [31:0],
	parameter rom_map_pkg::sdram_addr_t REGION_BASE = '0
) (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     req,
	input  rom_map_pkg::sdram_addr_t addr,
	output logic                     ack,
	output data_t                    data,
	output logic                     rd_valid,
	output bus_pkg::rd_req_t         rd_req,
	input  logic                     grant_done,
	input  bus_pkg::rd_data_t        rd_data
);
	import rom_map_pkg::*;

	// Payload width sets both the address scaling and the slice of rd_data kept
	localparam int DATA_BITS  = $bits(data_t);
	localparam int ADDR_SHIFT = $clog2(DATA_BITS / 8);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_ACK
	} state_t;

	state_t      state;
	sdram_addr_t byte_addr;

	// Client word address to SDRAM byte address
	assign byte_addr = REGION_BASE + (addr << ADDR_SHIFT);

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= ST_IDLE;
			rd_valid <= 1'b0;
			ack      <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// A new request only rises once ack has gone low
					if (req) begin
						rd_valid <= 1'b1;
						state    <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					// Data lands in the same edge that raises ack
					if (grant_done) begin
						rd_valid <= 1'b0;
						ack      <= 1'b1;
						state    <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!req) begin
						ack   <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and data registers
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && req)
			rd_req <= '{addr: byte_addr};
		if (state == ST_FETCH && grant_done)
			data <= data_t'(rd_data[DATA_BITS-1:0]);
	end

endmodule

//--- hdl/download_decoder.sv
`timescale 1ns/1ps
// Download decoder: DIP and title capture, ROM word to SDRAM write conversion
module download_decoder #(
	parameter int unsigned M68K_BYTES    = rom_map_pkg::M68K_BYTES,
	parameter int unsigned THEME_BYTES   = rom_map_pkg::THEME_BYTES,
	parameter int unsigned TILES_BYTES   = rom_map_pkg::TILES_BYTES,
	parameter int unsigned SPRITES_BYTES = rom_map_pkg::SPRITES_BYTES
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  bus_pkg::dl_word_t dl_word,
	input  logic              dl_wr,
	output logic              dl_wait,
	output logic [23:0]       dip_sw,
	output logic [3:0]        title_no,
	output logic              wr_valid,
	output bus_pkg::mem_req_t wr_req,
	input  logic              wr_done
);
	import rom_map_pkg::*;

	// Start offsets of each region in the download stream
	localparam sdram_addr_t THEME_START   = sdram_addr_t'(M68K_BYTES);
	localparam sdram_addr_t TILES_START   = sdram_addr_t'(M68K_BYTES + THEME_BYTES);
	localparam sdram_addr_t SPRITES_START = sdram_addr_t'(M68K_BYTES + THEME_BYTES
		+ TILES_BYTES);
	localparam sdram_addr_t ROM_END       = sdram_addr_t'(M68K_BYTES + THEME_BYTES
		+ TILES_BYTES + SPRITES_BYTES);

	logic        accept;
	logic        rom_hit;
	logic        rom_write;
	sdram_addr_t rom_addr;
	sdram_addr_t wr_addr;
	logic [15:0] wr_data;

	// The host is stalled for as long as a write is outstanding
	assign dl_wait = wr_valid;
	assign accept  = dl_wr & ~dl_wait;

	// Region lookup on the stream offset, in stream order
	always_comb begin
		rom_hit  = 1'b1;
		rom_addr = dl_word.addr;
		if (dl_word.addr < THEME_START) begin
			rom_addr = M68K_BASE + dl_word.addr;
		end else if (dl_word.addr < TILES_START) begin
			rom_addr = THEME_BASE + (dl_word.addr - THEME_START);
		end else if (dl_word.addr < SPRITES_START) begin
			rom_addr = TILES_BASE + (dl_word.addr - TILES_START);
		end else if (dl_word.addr < ROM_END) begin
			rom_addr = SPRITES_BASE + (dl_word.addr - SPRITES_START);
		end else begin
			// Past the last SDRAM region, taken from the host and dropped
			rom_hit = 1'b0;
		end
	end

	assign rom_write = accept && (dl_word.index == IDX_ROM) && rom_hit;

	// DIP bytes and title number
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dip_sw   <= '1;
			title_no <= 4'd1;
		end else if (accept) begin
			// Only the first four bytes of the DIP stream are meaningful
			if (dl_word.index == IDX_DIPS && dl_word.addr[26:2] == '0) begin
				if (!dl_word.addr[1])
					dip_sw[15:0] <= dl_word.data;
				else
					dip_sw[23:16] <= dl_word.data[7:0];
			end
			if (dl_word.index == IDX_TITLE)
				title_no <= dl_word.data[3:0];
		end
	end

	// Write request state, held until the arbiter reports completion
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_valid <= 1'b0;
		end else if (wr_valid) begin
			if (wr_done)
				wr_valid <= 1'b0;
		end else if (rom_write) begin
			wr_valid <= 1'b1;
		end
	end

	// Write address and data, loaded with the accepted ROM word
	always_ff @(posedge clk_sys) begin
		if (rom_write) begin
			wr_addr <= rom_addr;
			wr_data <= dl_word.data;
		end
	end

	assign wr_req = '{rd: 1'b0, wr: wr_valid, addr: wr_addr, wdata: wr_data};

endmodule

//--- hdl/bus_pkg.sv
// Bus structures: host download word, memory request, client read request and read word
package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Host download side
	////////////////////////////////////////////////////////////////////////////

	// One 16-bit word from the host, with its stream index and byte address
	// The byte address steps by two because the host runs in wide mode
	typedef struct packed {
		logic [15:0]              index;
		rom_map_pkg::sdram_addr_t addr;
		logic [15:0]              data;
	} dl_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////////////

	// Request towards the memory port
	// At most one of rd and wr is set, and the request is held until mem_ready
	typedef struct packed {
		logic                     rd;
		logic                     wr;
		rom_map_pkg::sdram_addr_t addr;
		logic [15:0]              wdata;
	} mem_req_t;

	////////////////////////////////////////////////////////////////////////////
	// Read clients
	////////////////////////////////////////////////////////////////////////////

	// Read request from a client port, already turned into an SDRAM byte address
	typedef struct packed {
		rom_map_pkg::sdram_addr_t addr;
	} rd_req_t;

	// Two consecutive 16-bit words, the addressed one in the low half
	typedef logic [31:0] rd_data_t;

endpackage

//--- hdl/rom_map_pkg.sv
// ROM map constants: SDRAM region bases, default region sizes, download index codes
package rom_map_pkg;

	// Byte address into the 128 MB SDRAM space
	typedef logic [26:0] sdram_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Region bases
	////////////////////////////////////////////////////////////////////////////

	// 68k program and theme share the low bank area
	localparam sdram_addr_t M68K_BASE    = 27'h000_0000;
	localparam sdram_addr_t THEME_BASE   = 27'h010_0000;

	// Graphics data sits higher up, tiles first then sprites
	localparam sdram_addr_t TILES_BASE   = 27'h100_0000;
	localparam sdram_addr_t SPRITES_BASE = 27'h120_0000;

	////////////////////////////////////////////////////////////////////////////
	// Region sizes in the download stream
	////////////////////////////////////////////////////////////////////////////

	// These are defaults only, the top level can override them per title
	localparam int unsigned M68K_BYTES    = 384 * 1024;
	localparam int unsigned THEME_BYTES   = 512 * 1024;
	localparam int unsigned TILES_BYTES   = 1024 * 1024;
	localparam int unsigned SPRITES_BYTES = 2048 * 1024;

	// The stream carries the regions back to back in this order:
	// 68k program, theme, tiles, sprites
	// Anything past the sprites belongs to on-chip ROMs that are not handled here

	////////////////////////////////////////////////////////////////////////////
	// Download index codes
	////////////////////////////////////////////////////////////////////////////

	// Index 0 is the ROM image itself
	localparam logic [15:0] IDX_ROM   = 16'd0;

	// Index 1 carries the title number in its low nibble
	localparam logic [15:0] IDX_TITLE = 16'd1;

	// Index 254 carries the DIP switch bytes
	localparam logic [15:0] IDX_DIPS  = 16'd254;

endpackage
